// File: dv/ooo_issue_checker.sv
`timescale 1ns/1ps

`include "ooo_issue_macros.svh"

module ooo_issue_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`RS_NUM_ENTS-1:0] gnt,
    input logic                    iss_valid,
    input logic                    disp_valid,
    input logic                    rs_stall
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // Issue packet appears exactly one cycle after a grant
    a_iss_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        (|gnt) |=> iss_valid)
        else begin
            $error("iss_valid missing one cycle after a grant");
            fail_count++;
        end

    a_no_iss_without_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        !(|gnt) |=> !iss_valid)
        else begin
            $error("iss_valid raised without a grant in the previous cycle");
            fail_count++;
        end

    // At most one entry granted per cycle
    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt))
        else begin
            $error("more than one entry granted in the same cycle");
            fail_count++;
        end

    // Upstream must hold while the station is full
    a_no_disp_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        !(disp_valid && rs_stall))
        else begin
            $error("dispatch while rs_stall is high");
            fail_count++;
        end

endmodule

bind rs ooo_issue_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .gnt        (ent_gnt),
    .iss_valid  (iss_valid),
    .disp_valid (disp_valid),
    .rs_stall   (rs_stall)
);

// File: dv/ooo_issue_tb.sv
`timescale 1ns/1ps

`include "ooo_issue_macros.svh"

module ooo_issue_tb;

    localparam int NUM_UOPS       = 360;
    localparam int TIMEOUT_CYCLES = NUM_UOPS * 8 + 100;
    localparam int NREG           = `PRF_NUM_REGS;
    // Station plus rs2 and execute, each link of a chain taking three cycles
    localparam int DRAIN_CYCLES   = (`RS_NUM_ENTS + 3) * 3 + 16;

    logic                       clk;
    logic                       rst_n;
    logic                       disp_valid;
    ooo_issue_pkg::t_uop_op     disp_op;
    ooo_issue_pkg::t_prf_id     disp_pdst;
    ooo_issue_pkg::t_prf_id     disp_psrc1;
    ooo_issue_pkg::t_src2_field disp_src2;
    logic                       rs_stall;
    logic                       wb_valid;
    ooo_issue_pkg::t_prf_id     wb_pdst;
    ooo_issue_pkg::t_data       wb_data;

    // Renamer and reference state
    ooo_issue_pkg::t_data   model_val [NREG];
    bit                     in_flight [NREG];
    bit                     allocated [NREG];
    int                     readers   [NREG];
    ooo_issue_pkg::t_prf_id src_reg   [NREG][2];
    bit                     src_used  [NREG][2];
    int                     outstanding;
    int                     dispatched;
    int                     cycle_count;
    int                     drain_cycles;
    bit                     stall_seen;
    logic [31:0]            lfsr_state;
    string                  cur_test;

    ooo_issue_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_valid (disp_valid),
        .disp_op    (disp_op),
        .disp_pdst  (disp_pdst),
        .disp_psrc1 (disp_psrc1),
        .disp_src2  (disp_src2),
        .rs_stall   (rs_stall),
        .wb_valid   (wb_valid),
        .wb_pdst    (wb_pdst),
        .wb_data    (wb_data)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bit reads_src2(input ooo_issue_pkg::t_uop_op op);
        return !(op inside {ooo_issue_pkg::OP_LI, ooo_issue_pkg::OP_ADDI});
    endfunction

    // Reference result from the opcode rules
    function automatic ooo_issue_pkg::t_data expected_result(input ooo_issue_pkg::t_uop_op op,
            input ooo_issue_pkg::t_data a, input ooo_issue_pkg::t_data b,
            input logic [`IMM_W-1:0] imm);
        ooo_issue_pkg::t_data sext;
        sext = $signed(imm);
        case (op)
            ooo_issue_pkg::OP_LI:   return sext;
            ooo_issue_pkg::OP_ADDI: return a + sext;
            ooo_issue_pkg::OP_ADD:  return a + b;
            ooo_issue_pkg::OP_SUB:  return a - b;
            ooo_issue_pkg::OP_AND:  return a & b;
            default:                return a ^ b;
        endcase
    endfunction

    // Random source among allocated registers and never the destination
    function automatic ooo_issue_pkg::t_prf_id pick_src(input int excl, input bit ready_only);
        int start;
        int idx;
        start = take_bits(5);
        for (int k = 0; k < NREG; k++) begin
            idx = (start + k) % NREG;
            if (allocated[idx] && idx != excl && !(ready_only && in_flight[idx])) begin
                return idx;
            end
        end
        return '0;
    endfunction

    // Free means no write in flight and no pending reader
    task automatic pick_dest(output ooo_issue_pkg::t_prf_id dst);
        int start;
        int idx;
        bit found;
        found = 0;
        while (!found) begin
            start = take_bits(5);
            for (int k = 0; k < NREG; k++) begin
                idx = (start + k) % NREG;
                if (!found && !in_flight[idx] && readers[idx] == 0) begin
                    dst = idx;
                    found = 1;
                end
            end
            if (!found) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic dispatch_uop(input ooo_issue_pkg::t_uop_op op,
            input ooo_issue_pkg::t_prf_id dst, input ooo_issue_pkg::t_prf_id s1,
            input ooo_issue_pkg::t_prf_id s2, input logic [`IMM_W-1:0] imm);
        ooo_issue_pkg::t_data a;
        ooo_issue_pkg::t_data b;
        bit use1;
        bit use2;
        while (rs_stall) begin
            @(posedge clk);
            #1;
        end
        use1 = ooo_issue_pkg::op_uses_src1(op);
        use2 = reads_src2(op);
        a = use1 ? model_val[s1] : '0;
        b = use2 ? model_val[s2] : '0;
        model_val[dst] = expected_result(op, a, b, imm);
        in_flight[dst] = 1;
        allocated[dst] = 1;
        src_reg[dst][0] = s1;
        src_reg[dst][1] = s2;
        src_used[dst][0] = use1;
        src_used[dst][1] = use2;
        if (use1) readers[s1]++;
        if (use2) readers[s2]++;
        outstanding++;
        dispatched++;
        disp_valid = 1'b1;
        disp_op    = op;
        disp_pdst  = dst;
        disp_psrc1 = use1 ? s1 : '0;
        disp_src2  = '0;
        if (use2) begin
            disp_src2.r.preg = s2;
        end else begin
            disp_src2.imm = imm;
        end
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic dispatch_random(input ooo_issue_pkg::t_uop_op op, input bit ready_only);
        ooo_issue_pkg::t_prf_id d;
        ooo_issue_pkg::t_prf_id s1;
        ooo_issue_pkg::t_prf_id s2;
        pick_dest(d);
        s1 = pick_src(d, ready_only);
        s2 = pick_src(d, ready_only);
        dispatch_uop(op, d, s1, s2, take_bits(`IMM_W));
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic load_immediates();
        ooo_issue_pkg::t_prf_id d;
        logic [`IMM_W-1:0] imm;
        cur_test = "li_burst";
        for (int i = 0; i < 12; i++) begin
            // Most negative and minus one first
            imm = (i == 0) ? 12'h800 : (i == 1) ? 12'hfff : take_bits(`IMM_W);
            pick_dest(d);
            dispatch_uop(ooo_issue_pkg::OP_LI, d, '0, '0, imm);
        end
        wait_drain();
    endtask

    task automatic reg_arith_ops();
        cur_test = "reg_arith";
        for (int i = 0; i < 16; i++) begin
            dispatch_random(ooo_issue_pkg::t_uop_op'(ooo_issue_pkg::OP_ADD + i % 4), 1'b1);
        end
        wait_drain();
    endtask

    task automatic addi_chain();
        ooo_issue_pkg::t_prf_id prev;
        ooo_issue_pkg::t_prf_id d;
        cur_test = "addi_chain";
        prev = pick_src(-1, 1'b1);
        for (int i = 0; i < 10; i++) begin
            pick_dest(d);
            dispatch_uop(ooo_issue_pkg::OP_ADDI, d, prev, '0, take_bits(`IMM_W));
            prev = d;
        end
        wait_drain();
    endtask

    // Consumer dispatched in the cycle its producer writes back
    task automatic same_cycle_wakeup();
        ooo_issue_pkg::t_prf_id prod;
        ooo_issue_pkg::t_prf_id d;
        ooo_issue_pkg::t_uop_op op;
        cur_test = "same_cycle_wakeup";
        for (int i = 0; i < 4; i++) begin
            pick_dest(prod);
            dispatch_uop(ooo_issue_pkg::OP_LI, prod, '0, '0, take_bits(`IMM_W));
            pick_dest(d);
            op = (i % 2 == 0) ? ooo_issue_pkg::OP_ADDI : ooo_issue_pkg::OP_SUB;
            while (!(wb_valid && wb_pdst == prod)) begin
                @(posedge clk);
                #1;
            end
            dispatch_uop(op, d, prod, pick_src(d, 1'b1), take_bits(`IMM_W));
            wait_drain();
        end
    endtask

    // A slow ADDI chain keeps eight consumers waiting until the station fills
    task automatic fill_station();
        ooo_issue_pkg::t_prf_id prev;
        ooo_issue_pkg::t_prf_id d;
        cur_test = "full_station";
        stall_seen = 0;
        prev = pick_src(-1, 1'b1);
        for (int i = 0; i < 6; i++) begin
            pick_dest(d);
            dispatch_uop(ooo_issue_pkg::OP_ADDI, d, prev, '0, take_bits(`IMM_W));
            prev = d;
        end
        for (int i = 0; i < 8; i++) begin
            pick_dest(d);
            dispatch_uop((i % 2 == 0) ? ooo_issue_pkg::OP_ADDI : ooo_issue_pkg::OP_XOR,
                         d, prev, pick_src(d, 1'b1), take_bits(`IMM_W));
        end
        wait_drain();
        assert (stall_seen) else stop_on_error("rs_stall never rose with the station full");
    endtask

    task automatic random_mix();
        cur_test = "random_mix";
        for (int i = 0; i < 300; i++) begin
            dispatch_random(ooo_issue_pkg::t_uop_op'(take_bits(3) % 6), 1'b0);
        end
    endtask

    // Writeback compare
    always @(posedge clk) begin
        if (rst_n && rs_stall) begin
            stall_seen = 1;
        end
        if (rst_n && wb_valid) begin
            assert (in_flight[wb_pdst]) else stop_on_error($sformatf(
                "Writeback to p%0d with no micro-op outstanding in %s", wb_pdst, cur_test));
            assert (wb_data === model_val[wb_pdst]) else stop_on_error($sformatf(
                "MISMATCH %s p%0d expected %h actual %h",
                cur_test, wb_pdst, model_val[wb_pdst], wb_data));
            for (int k = 0; k < 2; k++) begin
                if (src_used[wb_pdst][k]) begin
                    assert (!in_flight[src_reg[wb_pdst][k]]) else stop_on_error($sformatf(
                        "p%0d wrote back before its producer p%0d in %s",
                        wb_pdst, src_reg[wb_pdst][k], cur_test));
                    readers[src_reg[wb_pdst][k]]--;
                end
            end
            in_flight[wb_pdst] = 0;
            outstanding--;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (UUT.u_rs.u_checker.fail_count != 0) begin
            stop_on_error($sformatf("Station assertion checker flagged a violation in %s",
                                    cur_test));
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout after %0d cycles with %0d micro-ops outstanding",
                                    cycle_count, outstanding));
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        disp_valid   = 1'b0;
        disp_op      = ooo_issue_pkg::OP_LI;
        disp_pdst    = '0;
        disp_psrc1   = '0;
        disp_src2    = '0;
        outstanding  = 0;
        dispatched   = 0;
        cycle_count  = 0;
        drain_cycles = 0;
        stall_seen   = 0;
        lfsr_state   = 32'd78530;
        cur_test     = "reset";
        for (int r = 0; r < NREG; r++) begin
            model_val[r] = '0;
            in_flight[r] = 0;
            allocated[r] = 0;
            readers[r]   = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        load_immediates();
        reg_arith_ops();
        addi_chain();
        same_cycle_wakeup();
        fill_station();
        random_mix();

        // Whatever is still in the station must retire within the drain window
        while (outstanding != 0 && drain_cycles < DRAIN_CYCLES) begin
            @(posedge clk);
            #1;
            drain_cycles++;
        end

        if (outstanding == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error($sformatf("Lost micro-ops: %0d dispatched, %0d never written back",
                                    dispatched, outstanding));
        end
    end

endmodule

// File: hdl/alu_exec.sv
`timescale 1ns/1ps

`include "ooo_issue_macros.svh"

module alu_exec (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    iss_valid,
    input  ooo_issue_pkg::t_uop_op  iss_op,
    input  ooo_issue_pkg::t_prf_id  iss_pdst,
    input  ooo_issue_pkg::t_data    iss_src1_val,
    input  ooo_issue_pkg::t_data    iss_src2_val,
    input  logic [`IMM_W-1:0]       iss_imm,

    output logic                    wb_valid,
    output ooo_issue_pkg::t_prf_id  wb_pdst,
    output ooo_issue_pkg::t_data    wb_data
);

    ooo_issue_pkg::t_data imm_sext;
    ooo_issue_pkg::t_data result;

    assign imm_sext = {{(`DATA_W - `IMM_W){iss_imm[`IMM_W-1]}}, iss_imm};

    always_comb begin
        case (iss_op)
            ooo_issue_pkg::OP_LI:   result = imm_sext;
            ooo_issue_pkg::OP_ADDI: result = iss_src1_val + imm_sext;
            ooo_issue_pkg::OP_ADD:  result = iss_src1_val + iss_src2_val;
            ooo_issue_pkg::OP_SUB:  result = iss_src1_val - iss_src2_val;
            ooo_issue_pkg::OP_AND:  result = iss_src1_val & iss_src2_val;
            ooo_issue_pkg::OP_XOR:  result = iss_src1_val ^ iss_src2_val;
            default:                result = '0;
        endcase
    end

    // Writeback one cycle after issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            wb_pdst <= iss_pdst;
            wb_data <= result;
        end
    end

endmodule

// File: hdl/ooo_issue_macros.svh
`ifndef OOO_ISSUE_MACROS_SVH
`define OOO_ISSUE_MACROS_SVH

// Reservation station depth
`define RS_NUM_ENTS 8

// Physical register file size and tag width
`define PRF_NUM_REGS 32
`define PRF_ID_W 5

// Datapath width
`define DATA_W 32

// Width of the immediate carried in the second operand field
`define IMM_W 12

`endif

// File: hdl/ooo_issue_pkg.sv
`include "ooo_issue_macros.svh"

package ooo_issue_pkg;

    // Physical register tag
    typedef logic [`PRF_ID_W-1:0] t_prf_id;

    // Data word as held in the register file
    typedef logic [`DATA_W-1:0] t_data;

    // Micro-op opcodes
    typedef enum logic [2:0] {
        OP_LI   = 3'd0,
        OP_ADDI = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_AND  = 3'd4,
        OP_XOR  = 3'd5
    } t_uop_op;

    // Register view of the second operand field
    typedef struct packed {
        logic [`IMM_W-`PRF_ID_W-1:0] pad;
        t_prf_id                     preg;
    } t_src2_reg;

    // Second operand field read as a register tag or an immediate by opcode
    // LI and ADDI read it as an immediate, everything else as a tag
    typedef union packed {
        t_src2_reg             r;
        logic [`IMM_W-1:0]     imm;
    } t_src2_field;

    // Only LI has no first source
    function automatic logic op_uses_src1(input t_uop_op op);
        return (op != OP_LI);
    endfunction

endpackage

// File: hdl/ooo_issue_top.sv
`timescale 1ns/1ps

`include "ooo_issue_macros.svh"

module ooo_issue_top (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       disp_valid,
    input  ooo_issue_pkg::t_uop_op     disp_op,
    input  ooo_issue_pkg::t_prf_id     disp_pdst,
    input  ooo_issue_pkg::t_prf_id     disp_psrc1,
    input  ooo_issue_pkg::t_src2_field disp_src2,
    output logic                       rs_stall,

    output logic                       wb_valid,
    output ooo_issue_pkg::t_prf_id     wb_pdst,
    output ooo_issue_pkg::t_data       wb_data
);

    logic [`PRF_NUM_REGS-1:0]     prf_ready;
    logic [1:0]                   prf_rd_en;
    ooo_issue_pkg::t_prf_id [1:0] prf_rd_addr;
    ooo_issue_pkg::t_data [1:0]   prf_rd_data;

    logic                         iss_valid;
    ooo_issue_pkg::t_uop_op       iss_op;
    ooo_issue_pkg::t_prf_id       iss_pdst;
    ooo_issue_pkg::t_data         iss_src1_val;
    ooo_issue_pkg::t_data         iss_src2_val;
    logic [`IMM_W-1:0]            iss_imm;

    rs u_rs (
        .clk          (clk),
        .rst_n        (rst_n),
        .disp_valid   (disp_valid),
        .disp_op      (disp_op),
        .disp_pdst    (disp_pdst),
        .disp_psrc1   (disp_psrc1),
        .disp_src2    (disp_src2),
        .rs_stall     (rs_stall),
        .prf_ready    (prf_ready),
        .wb_valid     (wb_valid),
        .wb_pdst      (wb_pdst),
        .prf_rd_en    (prf_rd_en),
        .prf_rd_addr  (prf_rd_addr),
        .prf_rd_data  (prf_rd_data),
        .iss_valid    (iss_valid),
        .iss_op       (iss_op),
        .iss_pdst     (iss_pdst),
        .iss_src1_val (iss_src1_val),
        .iss_src2_val (iss_src2_val),
        .iss_imm      (iss_imm)
    );

    // Scoreboard follows dispatch directly
    prf u_prf (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp_valid  (disp_valid),
        .disp_pdst   (disp_pdst),
        .wb_valid    (wb_valid),
        .wb_pdst     (wb_pdst),
        .wb_data     (wb_data),
        .prf_rd_en   (prf_rd_en),
        .prf_rd_addr (prf_rd_addr),
        .prf_rd_data (prf_rd_data),
        .prf_ready   (prf_ready)
    );

    alu_exec u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .iss_valid    (iss_valid),
        .iss_op       (iss_op),
        .iss_pdst     (iss_pdst),
        .iss_src1_val (iss_src1_val),
        .iss_src2_val (iss_src2_val),
        .iss_imm      (iss_imm),
        .wb_valid     (wb_valid),
        .wb_pdst      (wb_pdst),
        .wb_data      (wb_data)
    );

endmodule

// File: hdl/prf.sv
`timescale 1ns/1ps

`include "ooo_issue_macros.svh"

module prf (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         disp_valid,
    input  ooo_issue_pkg::t_prf_id       disp_pdst,

    input  logic                         wb_valid,
    input  ooo_issue_pkg::t_prf_id       wb_pdst,
    input  ooo_issue_pkg::t_data         wb_data,

    input  logic [1:0]                   prf_rd_en,
    input  ooo_issue_pkg::t_prf_id [1:0] prf_rd_addr,
    output ooo_issue_pkg::t_data [1:0]   prf_rd_data,

    output logic [`PRF_NUM_REGS-1:0]     prf_ready
);

    ooo_issue_pkg::t_data regs [`PRF_NUM_REGS];

    // All registers read as zero out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wb_valid) begin
            regs[wb_pdst] <= wb_data;
        end
    end

    // Ready scoreboard
    // Dispatch and writeback never target the same tag in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prf_ready <= '1;
        end else begin
            if (disp_valid) begin
                prf_ready[disp_pdst] <= 1'b0;
            end
            if (wb_valid) begin
                prf_ready[wb_pdst] <= 1'b1;
            end
        end
    end

    // Registered read ports
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (prf_rd_en[p]) begin
                prf_rd_data[p] <= regs[prf_rd_addr[p]];
            end
        end
    end

endmodule

// File: hdl/rs.sv
`timescale 1ns/1ps

`include "ooo_issue_macros.svh"

module rs #(
    parameter int NUM_ENTS = `RS_NUM_ENTS
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         disp_valid,
    input  ooo_issue_pkg::t_uop_op       disp_op,
    input  ooo_issue_pkg::t_prf_id       disp_pdst,
    input  ooo_issue_pkg::t_prf_id       disp_psrc1,
    input  ooo_issue_pkg::t_src2_field   disp_src2,
    output logic                         rs_stall,

    input  logic [`PRF_NUM_REGS-1:0]     prf_ready,

    input  logic                         wb_valid,
    input  ooo_issue_pkg::t_prf_id       wb_pdst,

    output logic [1:0]                   prf_rd_en,
    output ooo_issue_pkg::t_prf_id [1:0] prf_rd_addr,
    input  ooo_issue_pkg::t_data [1:0]   prf_rd_data,

    output logic                         iss_valid,
    output ooo_issue_pkg::t_uop_op       iss_op,
    output ooo_issue_pkg::t_prf_id       iss_pdst,
    output ooo_issue_pkg::t_data         iss_src1_val,
    output ooo_issue_pkg::t_data         iss_src2_val,
    output logic [`IMM_W-1:0]            iss_imm
);

    logic [NUM_ENTS-1:0]         ent_valid;
    logic [NUM_ENTS-1:0]         ent_req;
    logic [NUM_ENTS-1:0]         ent_gnt;
    logic [NUM_ENTS-1:0]         ent_alloc;
    ooo_issue_pkg::t_uop_op      ent_op    [NUM_ENTS];
    ooo_issue_pkg::t_prf_id      ent_pdst  [NUM_ENTS];
    ooo_issue_pkg::t_prf_id      ent_psrc1 [NUM_ENTS];
    ooo_issue_pkg::t_src2_field  ent_src2  [NUM_ENTS];
    logic [1:0]                  ent_uses  [NUM_ENTS];

    logic [1:0]                  alloc_rdy;

    logic                        sel_valid;
    ooo_issue_pkg::t_uop_op      sel_op;
    ooo_issue_pkg::t_prf_id      sel_pdst;
    ooo_issue_pkg::t_prf_id      sel_psrc1;
    ooo_issue_pkg::t_src2_field  sel_src2;
    logic [1:0]                  sel_uses;

    logic [1:0]                  uses_rs2;

    // Lowest set bit as a one-hot vector
    function automatic logic [NUM_ENTS-1:0] first_one(input logic [NUM_ENTS-1:0] vec);
        logic [NUM_ENTS-1:0] onehot;
        onehot = '0;
        for (int i = NUM_ENTS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                onehot = '0;
                onehot[i] = 1'b1;
            end
        end
        return onehot;
    endfunction

    // Allocation into the first free entry
    assign rs_stall  = &ent_valid;
    assign ent_alloc = disp_valid ? first_one(~ent_valid) : '0;

    // Source readiness at allocation, including a same-cycle writeback
    assign alloc_rdy[0] = prf_ready[disp_psrc1] || (wb_valid && (wb_pdst == disp_psrc1));
    assign alloc_rdy[1] = prf_ready[disp_src2.r.preg] ||
                          (wb_valid && (wb_pdst == disp_src2.r.preg));

    for (genvar i = 0; i < NUM_ENTS; i++) begin : g_ent
        rs_entry u_entry (
            .clk         (clk),
            .rst_n       (rst_n),
            .alloc       (ent_alloc[i]),
            .alloc_op    (disp_op),
            .alloc_pdst  (disp_pdst),
            .alloc_psrc1 (disp_psrc1),
            .alloc_src2  (disp_src2),
            .alloc_ready (alloc_rdy),
            .wb_valid    (wb_valid),
            .wb_pdst     (wb_pdst),
            .gnt         (ent_gnt[i]),
            .valid       (ent_valid[i]),
            .req         (ent_req[i]),
            .op          (ent_op[i]),
            .pdst        (ent_pdst[i]),
            .psrc1       (ent_psrc1[i]),
            .src2        (ent_src2[i]),
            .uses_src    (ent_uses[i])
        );
    end

    // Stage rs1 grants the lowest requester
    assign sel_valid = |ent_req;
    assign ent_gnt   = first_one(ent_req);

    always_comb begin
        sel_op    = ooo_issue_pkg::OP_LI;
        sel_pdst  = '0;
        sel_psrc1 = '0;
        sel_src2  = '0;
        sel_uses  = 2'b00;
        for (int i = 0; i < NUM_ENTS; i++) begin
            if (ent_gnt[i]) begin
                sel_op    = ent_op[i];
                sel_pdst  = ent_pdst[i];
                sel_psrc1 = ent_psrc1[i];
                sel_src2  = ent_src2[i];
                sel_uses  = ent_uses[i];
            end
        end
    end

    // Register file read for the selected micro-op
    assign prf_rd_en[0]   = sel_valid && sel_uses[0];
    assign prf_rd_addr[0] = sel_psrc1;
    assign prf_rd_en[1]   = sel_valid && sel_uses[1];
    assign prf_rd_addr[1] = sel_src2.r.preg;

    // rs2 staging
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
            uses_rs2  <= 2'b00;
        end else begin
            iss_valid <= sel_valid;
            uses_rs2  <= prf_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            iss_op   <= sel_op;
            iss_pdst <= sel_pdst;
            iss_imm  <= sel_src2.imm;
        end
    end

    // Read data lands in rs2 and is zeroed where a source is unused
    assign iss_src1_val = uses_rs2[0] ? prf_rd_data[0] : '0;
    assign iss_src2_val = uses_rs2[1] ? prf_rd_data[1] : '0;

endmodule

// File: hdl/rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      alloc,
    input  ooo_issue_pkg::t_uop_op    alloc_op,
    input  ooo_issue_pkg::t_prf_id    alloc_pdst,
    input  ooo_issue_pkg::t_prf_id    alloc_psrc1,
    input  ooo_issue_pkg::t_src2_field alloc_src2,
    input  logic [1:0]                alloc_ready,

    input  logic                      wb_valid,
    input  ooo_issue_pkg::t_prf_id    wb_pdst,

    input  logic                      gnt,

    output logic                      valid,
    output logic                      req,

    output ooo_issue_pkg::t_uop_op    op,
    output ooo_issue_pkg::t_prf_id    pdst,
    output ooo_issue_pkg::t_prf_id    psrc1,
    output ooo_issue_pkg::t_src2_field src2,
    output logic [1:0]                uses_src
);

    logic [1:0] src_rdy;
    logic [1:0] wake;

    // Source usage from the held opcode
    assign uses_src[0] = ooo_issue_pkg::op_uses_src1(op);
    assign uses_src[1] = (op != ooo_issue_pkg::OP_LI) && (op != ooo_issue_pkg::OP_ADDI);

    // Tag match against the writeback broadcast
    // src2 is only a tag under the register view
    assign wake[0] = wb_valid && (wb_pdst == psrc1);
    assign wake[1] = wb_valid && uses_src[1] && (wb_pdst == src2.r.preg);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            src_rdy <= 2'b00;
        end else if (alloc) begin
            valid   <= 1'b1;
            src_rdy <= alloc_ready;
        end else begin
            if (gnt) begin
                valid <= 1'b0;
            end
            src_rdy <= src_rdy | wake;
        end
    end

    // Micro-op payload, loaded on allocation
    always_ff @(posedge clk) begin
        if (alloc) begin
            op    <= alloc_op;
            pdst  <= alloc_pdst;
            psrc1 <= alloc_psrc1;
            src2  <= alloc_src2;
        end
    end

    // Unused sources count as ready
    assign req = valid && (&(src_rdy | ~uses_src));

endmodule

// File: ooo_issue.f
+incdir+hdl
hdl/ooo_issue_pkg.sv
hdl/rs_entry.sv
hdl/rs.sv
hdl/prf.sv
hdl/alu_exec.sv
hdl/ooo_issue_top.sv
dv/ooo_issue_checker.sv
dv/ooo_issue_tb.sv
